/* hw/xgmii_rx_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the xgmii receive path: bus widths,
// xgmii and ethernet codes, crc-32 constants and the frame state enum
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xgmii_rx_pkg;

    // one 32-bit xgmii word, lane 0 in the low byte
    typedef logic [31:0] xgmii_data_t;
    typedef logic [3:0]  xgmii_ctrl_t;

    // one flag per byte lane
    typedef logic [3:0]  lane_mask_t;

    typedef logic [31:0] crc_t;
    typedef logic [15:0] stat_count_t;

    // xgmii control characters
    localparam logic [7:0] xgmii_idle  = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hFB;
    localparam logic [7:0] xgmii_term  = 8'hFD;
    localparam logic [7:0] xgmii_error = 8'hFE;

    // preamble and start frame delimiter
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hD5;

    // reflected crc-32, lsb first
    localparam crc_t crc_poly_rev = 32'hEDB88320;
    localparam crc_t crc_init     = 32'hFFFFFFFF;

    // remainder left once the fcs itself has passed through the crc
    localparam crc_t crc_residue  = 32'hDEBB20E3;

    typedef enum logic [1:0] {
        rx_idle,
        rx_preamble,
        rx_payload,
        rx_last
    } rx_state_t;

endpackage

`default_nettype wire

/* hw/xgmii_rx_delay.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// three-stage xgmii delay line with lane-wise terminate and error
// detection, terminate masking and start detection at the last stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_rx_delay (
    input  wire                        clk,
    input  wire                        reset_crc,
    input  wire xgmii_rx_pkg::xgmii_data_t xgmii_rxd,
    input  wire xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    output xgmii_rx_pkg::xgmii_data_t  rxd_d0,
    output xgmii_rx_pkg::xgmii_data_t  rxd_d2,
    output xgmii_rx_pkg::xgmii_ctrl_t  rxc_d2,
    output xgmii_rx_pkg::lane_mask_t   detect_term,
    output logic                       masked_ctrl,
    output xgmii_rx_pkg::lane_mask_t   term_keep,
    output logic                       start_d2
);
    import xgmii_rx_pkg::*;

    xgmii_data_t rxd_d1;
    xgmii_ctrl_t rxc_d0;
    xgmii_ctrl_t rxc_d1;
    lane_mask_t  detect_error;

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            rxc_d0 <= '0;
            rxc_d1 <= '0;
            rxc_d2 <= '0;
        end else begin
            rxc_d0 <= xgmii_rxc;
            rxc_d1 <= rxc_d0;
            rxc_d2 <= rxc_d1;
        end
    end

    always_ff @(posedge clk) begin
        rxd_d0 <= xgmii_rxd;
        rxd_d1 <= rxd_d0;
        rxd_d2 <= rxd_d1;
    end

    // per-lane compare on the newest word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            detect_term[i]  = rxc_d0[i] && (rxd_d0[8*i +: 8] == xgmii_term);
            detect_error[i] = rxc_d0[i] && (rxd_d0[8*i +: 8] == xgmii_error);
        end
    end

    // lanes that precede the first terminate
    always_comb begin
        casez (detect_term)
            4'b???1: term_keep = 4'b0000;
            4'b??10: term_keep = 4'b0001;
            4'b?100: term_keep = 4'b0011;
            4'b1000: term_keep = 4'b0111;
            default: term_keep = 4'b1111;
        endcase
    end

    // characters after the terminate belong to the idle gap
    assign masked_ctrl = (|(rxc_d0 & term_keep)) || (|(detect_error & term_keep));

    assign start_d2 = rxc_d2[0] && (rxd_d2[7:0] == xgmii_start);

endmodule

`default_nettype wire

/* hw/eth_crc32_lanes.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// running ethernet crc-32 over 32-bit words, with next states for one
// to four lanes and registered residue-match flags per lane count
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module eth_crc32_lanes (
    input  wire                        clk,
    input  wire                        reset_crc,
    input  wire xgmii_rx_pkg::xgmii_data_t data,
    input  wire                        crc_clear,
    input  wire                        crc_update,
    output xgmii_rx_pkg::lane_mask_t   crc_match
);
    import xgmii_rx_pkg::*;

    crc_t       crc_state;
    crc_t       crc_next [4];
    lane_mask_t residue_hit;

    // one byte through a reflected crc, bit 0 of the byte first
    function automatic logic [31:0] crc_byte(
        input logic [31:0] crc,
        input logic [7:0]  din,
        input logic [31:0] poly
    );
        logic [31:0] c;
        c = crc ^ {24'd0, din};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // crc_next[i] covers lanes 0..i of the word
    always_comb begin
        crc_next[0] = crc_byte(crc_state, data[7:0], crc_poly_rev);
        for (int i = 1; i < 4; i++) begin
            crc_next[i] = crc_byte(crc_next[i-1], data[8*i +: 8], crc_poly_rev);
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            residue_hit[i] = (crc_next[i] == crc_residue);
        end
    end

    // clear wins over update
    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_state <= crc_init;
            crc_match <= '0;
        end else if (crc_update) begin
            crc_state <= crc_next[3];
            crc_match <= residue_hit;
        end
    end

endmodule

`default_nettype wire

/* hw/xgmii_rx_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive frame FSM: crc control, registered output stream and the
// per-frame status pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_rx_ctrl (
    input  wire                        clk,
    input  wire                        reset_crc,
    input  wire xgmii_rx_pkg::xgmii_data_t rxd_d2,
    input  wire xgmii_rx_pkg::xgmii_ctrl_t rxc_d2,
    input  wire                        start_d2,
    input  wire                        masked_ctrl,
    input  wire xgmii_rx_pkg::lane_mask_t  detect_term,
    input  wire xgmii_rx_pkg::lane_mask_t  term_keep,
    input  wire xgmii_rx_pkg::lane_mask_t  crc_match,
    output logic                       crc_clear,
    output logic                       crc_update,
    output xgmii_rx_pkg::xgmii_data_t  m_axis_tdata,
    output xgmii_rx_pkg::lane_mask_t   m_axis_tkeep,
    output logic                       m_axis_tvalid,
    output logic                       m_axis_tlast,
    output logic                       m_axis_tuser,
    output logic                       start_packet,
    output logic                       error_bad_frame,
    output logic                       error_bad_fcs
);
    import xgmii_rx_pkg::*;

    rx_state_t   state;
    rx_state_t   state_next;

    // terminate position held for the extra beat
    lane_mask_t  last_keep;
    lane_mask_t  last_term;
    logic        save_term;
    logic        fcs_ok_last;
    logic        abort_beat;

    xgmii_data_t tdata_next;
    lane_mask_t  tkeep_next;
    logic        tvalid_next;
    logic        tlast_next;
    logic        tuser_next;
    logic        start_next;
    logic        bad_frame_next;
    logic        bad_fcs_next;

    // match flag for the fcs bytes that spilled into the terminate word
    assign fcs_ok_last = (last_term[1] && crc_match[0]) ||
                         (last_term[2] && crc_match[1]) ||
                         (last_term[3] && crc_match[2]);

    always_comb begin
        state_next     = state;
        crc_clear      = 1'b0;
        crc_update     = 1'b0;
        save_term      = 1'b0;
        abort_beat     = 1'b0;
        tdata_next     = rxd_d2;
        tkeep_next     = '0;
        tvalid_next    = 1'b0;
        tlast_next     = 1'b0;
        tuser_next     = 1'b0;
        start_next     = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next   = 1'b0;

        unique case (state)
            rx_idle: begin
                crc_clear = 1'b1;
                if (start_d2) begin
                    // d0 already holds the first payload word
                    if (masked_ctrl || (detect_term != '0)) begin
                        abort_beat = 1'b1;
                    end else begin
                        crc_clear  = 1'b0;
                        crc_update = 1'b1;
                        state_next = rx_preamble;
                    end
                end
            end
            rx_preamble: begin
                // d2 holds the preamble word ending in the sfd
                if ((rxd_d2[31:24] != eth_sfd) || masked_ctrl || (detect_term != '0)) begin
                    abort_beat = 1'b1;
                    crc_clear  = 1'b1;
                    state_next = rx_idle;
                end else begin
                    crc_update = 1'b1;
                    start_next = 1'b1;
                    state_next = rx_payload;
                end
            end
            rx_payload: begin
                crc_update  = 1'b1;
                tkeep_next  = ~rxc_d2;
                tvalid_next = 1'b1;
                if (masked_ctrl) begin
                    tlast_next     = 1'b1;
                    tuser_next     = 1'b1;
                    bad_frame_next = 1'b1;
                    crc_clear      = 1'b1;
                    state_next     = rx_idle;
                end else if (detect_term[0]) begin
                    // fcs filled the whole previous word
                    crc_clear  = 1'b1;
                    tkeep_next = 4'b1111;
                    tlast_next = 1'b1;
                    if (!crc_match[3]) begin
                        tuser_next     = 1'b1;
                        bad_frame_next = 1'b1;
                        bad_fcs_next   = 1'b1;
                    end
                    state_next = rx_idle;
                end else if (detect_term != '0) begin
                    save_term  = 1'b1;
                    state_next = rx_last;
                end
            end
            rx_last: begin
                crc_clear   = 1'b1;
                tkeep_next  = last_keep;
                tvalid_next = 1'b1;
                tlast_next  = 1'b1;
                if (!fcs_ok_last) begin
                    tuser_next     = 1'b1;
                    bad_frame_next = 1'b1;
                    bad_fcs_next   = 1'b1;
                end
                state_next = rx_idle;
            end
            default: begin
                state_next = rx_idle;
            end
        endcase

        // malformed start: one errored beat and back to idle
        if (abort_beat) begin
            tdata_next     = '0;
            tkeep_next     = 4'b0001;
            tvalid_next    = 1'b1;
            tlast_next     = 1'b1;
            tuser_next     = 1'b1;
            bad_frame_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state           <= rx_idle;
            m_axis_tvalid   <= 1'b0;
            m_axis_tlast    <= 1'b0;
            m_axis_tuser    <= 1'b0;
            start_packet    <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            state           <= state_next;
            m_axis_tvalid   <= tvalid_next;
            m_axis_tlast    <= tlast_next;
            m_axis_tuser    <= tuser_next;
            start_packet    <= start_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs   <= bad_fcs_next;
        end
    end

    always_ff @(posedge clk) begin
        m_axis_tdata <= tdata_next;
        m_axis_tkeep <= tkeep_next;
        if (save_term) begin
            last_keep <= term_keep;
            last_term <= detect_term;
        end
    end

endmodule

`default_nettype wire

/* hw/xgmii_rx_stats.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturating frame counters: good frames, bad frames and fcs errors
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_rx_stats (
    input  wire                        clk,
    input  wire                        reset_crc,
    input  wire                        m_axis_tvalid,
    input  wire                        m_axis_tlast,
    input  wire                        error_bad_frame,
    input  wire                        error_bad_fcs,
    output xgmii_rx_pkg::stat_count_t  count_good,
    output xgmii_rx_pkg::stat_count_t  count_bad,
    output xgmii_rx_pkg::stat_count_t  count_fcs
);
    import xgmii_rx_pkg::*;

    logic frame_end;

    // holds at all ones
    function automatic stat_count_t sat_inc(input stat_count_t value);
        if (value == '1) begin
            return value;
        end
        return value + 1'b1;
    endfunction

    // status pulses line up with the tlast beat
    assign frame_end = m_axis_tvalid && m_axis_tlast;

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            count_good <= '0;
            count_bad  <= '0;
            count_fcs  <= '0;
        end else begin
            if (frame_end && !error_bad_frame) begin
                count_good <= sat_inc(count_good);
            end
            if (frame_end && error_bad_frame) begin
                count_bad <= sat_inc(count_bad);
            end
            // an fcs error is also counted as a bad frame
            if (frame_end && error_bad_fcs) begin
                count_fcs <= sat_inc(count_fcs);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/xgmii_rx_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// xgmii receive top: delay line, crc, frame control and statistics
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_rx_top (
    input  wire                        clk,
    input  wire                        reset_crc,
    input  wire xgmii_rx_pkg::xgmii_data_t xgmii_rxd,
    input  wire xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    output xgmii_rx_pkg::xgmii_data_t  m_axis_tdata,
    output xgmii_rx_pkg::lane_mask_t   m_axis_tkeep,
    output logic                       m_axis_tvalid,
    output logic                       m_axis_tlast,
    output logic                       m_axis_tuser,
    output logic                       start_packet,
    output logic                       error_bad_frame,
    output logic                       error_bad_fcs,
    output xgmii_rx_pkg::stat_count_t  count_good,
    output xgmii_rx_pkg::stat_count_t  count_bad,
    output xgmii_rx_pkg::stat_count_t  count_fcs
);
    import xgmii_rx_pkg::*;

    wire xgmii_data_t rxd_d0;
    wire xgmii_data_t rxd_d2;
    wire xgmii_ctrl_t rxc_d2;
    wire lane_mask_t  detect_term;
    wire lane_mask_t  term_keep;
    wire lane_mask_t  crc_match;
    wire              masked_ctrl;
    wire              start_d2;
    wire              crc_clear;
    wire              crc_update;

    xgmii_rx_delay u_delay (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .xgmii_rxd   (xgmii_rxd),
        .xgmii_rxc   (xgmii_rxc),
        .rxd_d0      (rxd_d0),
        .rxd_d2      (rxd_d2),
        .rxc_d2      (rxc_d2),
        .detect_term (detect_term),
        .masked_ctrl (masked_ctrl),
        .term_keep   (term_keep),
        .start_d2    (start_d2)
    );

    // crc runs on the newest word, two words ahead of the output
    eth_crc32_lanes u_crc (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .data       (rxd_d0),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_match  (crc_match)
    );

    xgmii_rx_ctrl u_ctrl (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .rxd_d2          (rxd_d2),
        .rxc_d2          (rxc_d2),
        .start_d2        (start_d2),
        .masked_ctrl     (masked_ctrl),
        .detect_term     (detect_term),
        .term_keep       (term_keep),
        .crc_match       (crc_match),
        .crc_clear       (crc_clear),
        .crc_update      (crc_update),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tkeep    (m_axis_tkeep),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tuser    (m_axis_tuser),
        .start_packet    (start_packet),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs)
    );

    xgmii_rx_stats u_stats (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs),
        .count_good      (count_good),
        .count_bad       (count_bad),
        .count_fcs       (count_fcs)
    );

endmodule

`default_nettype wire

/* verification/xgmii_rx_clkgen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free-running testbench clock, period 100
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_rx_clkgen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verification/xgmii_rx_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the xgmii receive path: frame builder,
// reference crc-32, output monitor, compare tasks, watchdog and summary
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xgmii_rx_tb;
    import xgmii_rx_pkg::*;

    logic        clk;
    logic        reset_crc;
    xgmii_data_t xgmii_rxd;
    xgmii_ctrl_t xgmii_rxc;
    xgmii_data_t m_axis_tdata;
    lane_mask_t  m_axis_tkeep;
    logic        m_axis_tvalid;
    logic        m_axis_tlast;
    logic        m_axis_tuser;
    logic        start_packet;
    logic        error_bad_frame;
    logic        error_bad_fcs;
    stat_count_t count_good;
    stat_count_t count_bad;
    stat_count_t count_fcs;

    // payload bytes, words waiting to be driven, captured beats
    logic [7:0]  pay_mem [0:255];
    xgmii_data_t tx_data [0:511];
    xgmii_ctrl_t tx_ctrl [0:511];
    xgmii_data_t beat_data [0:255];
    lane_mask_t  beat_keep [0:255];
    logic        beat_last [0:255];
    logic        beat_user [0:255];
    logic        beat_bad [0:255];
    logic        beat_fcs [0:255];

    xgmii_data_t lane_data;
    xgmii_ctrl_t lane_ctrl;
    int          lane_fill = 0;
    int          tx_count = 0;
    int          words_driven = 0;
    int          cycle_count = 0;
    int          beat_count = 0;
    int          last_count = 0;
    int          start_count = 0;
    int          stray_count = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_ok = 0;
    int          tests_failed = 0;
    int          seed;
    stat_count_t exp_good = '0;
    stat_count_t exp_bad = '0;
    stat_count_t exp_fcs = '0;

    xgmii_rx_clkgen clkgen (
        .clk (clk)
    );

    xgmii_rx_top uut (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .xgmii_rxd       (xgmii_rxd),
        .xgmii_rxc       (xgmii_rxc),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tkeep    (m_axis_tkeep),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tuser    (m_axis_tuser),
        .start_packet    (start_packet),
        .error_bad_frame (error_bad_frame),
        .error_bad_fcs   (error_bad_fcs),
        .count_good      (count_good),
        .count_bad       (count_bad),
        .count_fcs       (count_fcs)
    );

    // limit grows with the words driven so far
    initial begin
        while (cycle_count <= 20 * words_driven + 200) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the DUT did not finish the frames within %0d cycles", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset_crc === 1'b0) begin
            if (start_packet) begin
                start_count++;
            end
            if ((error_bad_frame || error_bad_fcs) && !(m_axis_tvalid && m_axis_tlast)) begin
                stray_count++;
            end
            if (m_axis_tvalid && (beat_count < 256)) begin
                beat_data[beat_count] = m_axis_tdata;
                beat_keep[beat_count] = m_axis_tkeep;
                beat_last[beat_count] = m_axis_tlast;
                beat_user[beat_count] = m_axis_tuser;
                beat_bad[beat_count]  = error_bad_frame;
                beat_fcs[beat_count]  = error_bad_fcs;
                beat_count++;
                if (m_axis_tlast) begin
                    last_count++;
                end
            end
        end
    end

    task automatic expect_data(input string name, input xgmii_data_t exp, input xgmii_data_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_keep(input string name, input lane_mask_t exp, input lane_mask_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_count(input string name, input stat_count_t exp, input stat_count_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // one byte of the reflected crc-32 with the lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        r = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            r = r[0] ? ((r >> 1) ^ crc_poly_rev) : (r >> 1);
        end
        return r;
    endfunction

    function automatic xgmii_data_t lane_bits(input lane_mask_t keep);
        xgmii_data_t m;
        for (int j = 0; j < 4; j++) begin
            m[8*j +: 8] = {8{keep[j]}};
        end
        return m;
    endfunction

    // bytes fill lanes 0 to 3, then the word joins the send list
    task automatic push_byte(input logic [7:0] b, input logic c);
        lane_data[8*lane_fill +: 8] = b;
        lane_ctrl[lane_fill] = c;
        lane_fill++;
        if (lane_fill == 4) begin
            tx_data[tx_count] = lane_data;
            tx_ctrl[tx_count] = lane_ctrl;
            tx_count++;
            lane_fill = 0;
        end
    endtask

    task automatic make_payload(input int offset, input int len);
        logic [31:0] rnd;
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            pay_mem[offset + i] = rnd[7:0];
        end
    endtask

    task automatic append_idle(input int n);
        for (int i = 0; i < 4 * n; i++) begin
            push_byte(xgmii_idle, 1'b1);
        end
    endtask

    // start, preamble, sfd, payload, fcs, terminate and idle fill
    task automatic append_frame(input int offset, input int len, input bit flip_fcs,
                                input int err_index);
        logic [31:0] crc;
        logic [31:0] fcs;
        crc = crc_init;
        push_byte(xgmii_start, 1'b1);
        for (int i = 0; i < 6; i++) begin
            push_byte(eth_pre, 1'b0);
        end
        push_byte(eth_sfd, 1'b0);
        for (int i = 0; i < len; i++) begin
            crc = crc_step(crc, pay_mem[offset + i]);
            if (i == err_index) begin
                push_byte(xgmii_error, 1'b1);
            end else begin
                push_byte(pay_mem[offset + i], 1'b0);
            end
        end
        fcs = ~crc;
        if (flip_fcs) begin
            fcs[0] = ~fcs[0];
        end
        for (int i = 0; i < 4; i++) begin
            push_byte(fcs[8*i +: 8], 1'b0);
        end
        push_byte(xgmii_term, 1'b1);
        while (lane_fill != 0) begin
            push_byte(xgmii_idle, 1'b1);
        end
    endtask

    task automatic send_words();
        for (int i = 0; i < tx_count; i++) begin
            @(negedge clk);
            xgmii_rxd = tx_data[i];
            xgmii_rxc = tx_ctrl[i];
            words_driven++;
        end
        tx_count = 0;
        @(negedge clk);
        xgmii_rxd = {4{xgmii_idle}};
        xgmii_rxc = 4'hF;
    endtask

    // counters follow the tlast beat by one cycle
    task automatic wait_frames(input int n);
        while (last_count < n) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic begin_test();
        test_errors = errors;
        beat_count  = 0;
        last_count  = 0;
        start_count = 0;
        stray_count = 0;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - test_errors);
            tests_failed++;
        end
    endtask

    // len payload bytes expected from beat cursor on
    task automatic check_frame(input int offset, input int len, input bit bad, input bit fcs_bad,
                               inout int cursor);
        int          nbeats;
        int          idx;
        logic        is_last;
        xgmii_data_t exp_word;
        lane_mask_t  exp_keep;
        nbeats = (len + 3) / 4;
        if (beat_count < cursor + nbeats) begin
            $display("frame at offset %0d: only %0d of %0d beats arrived",
                     offset, beat_count - cursor, nbeats);
            errors++;
        end else begin
            for (int b = 0; b < nbeats; b++) begin
                exp_word = '0;
                exp_keep = '0;
                for (int j = 0; j < 4; j++) begin
                    idx = 4 * b + j;
                    if (idx < len) begin
                        exp_word[8*j +: 8] = pay_mem[offset + idx];
                        exp_keep[j] = 1'b1;
                    end
                end
                is_last = (b == nbeats - 1);
                expect_data("m_axis_tdata", exp_word,
                            beat_data[cursor + b] & lane_bits(exp_keep));
                expect_keep("m_axis_tkeep", exp_keep, beat_keep[cursor + b]);
                expect_flag("m_axis_tlast", is_last, beat_last[cursor + b]);
                expect_flag("m_axis_tuser", is_last && bad, beat_user[cursor + b]);
                expect_flag("error_bad_frame", is_last && bad, beat_bad[cursor + b]);
                expect_flag("error_bad_fcs", is_last && fcs_bad, beat_fcs[cursor + b]);
            end
            cursor = cursor + nbeats;
        end
    endtask

    task automatic pulse_totals(input int starts, input int beats);
        if (start_count != starts) begin
            $display("start_packet pulsed %0d times where %0d were expected", start_count, starts);
            errors++;
        end
        if (stray_count != 0) begin
            $display("an error pulse came without a tlast beat");
            errors++;
        end
        if (beat_count != beats) begin
            $display("the DUT sent %0d beats where %0d were expected", beat_count, beats);
            errors++;
        end
    endtask

    task automatic good_frame();
        int cursor;
        begin_test();
        make_payload(0, 16);
        append_frame(0, 16, 1'b0, -1);
        append_idle(2);
        send_words();
        wait_frames(1);
        cursor = 0;
        check_frame(0, 16, 1'b0, 1'b0, cursor);
        pulse_totals(1, cursor);
        exp_good++;
        finish_test("1 good 16-byte frame");
    endtask

    task automatic short_tails();
        int cursor;
        begin_test();
        for (int n = 13; n <= 15; n++) begin
            beat_count  = 0;
            last_count  = 0;
            start_count = 0;
            make_payload(0, n);
            append_frame(0, n, 1'b0, -1);
            append_idle(2);
            send_words();
            wait_frames(1);
            cursor = 0;
            check_frame(0, n, 1'b0, 1'b0, cursor);
            pulse_totals(1, cursor);
            exp_good++;
        end
        finish_test("2 partial last words");
    endtask

    task automatic corrupted_fcs();
        int cursor;
        begin_test();
        make_payload(0, 20);
        append_frame(0, 20, 1'b1, -1);
        append_idle(2);
        send_words();
        wait_frames(1);
        cursor = 0;
        check_frame(0, 20, 1'b1, 1'b1, cursor);
        pulse_totals(1, cursor);
        exp_bad++;
        exp_fcs++;
        finish_test("3 inverted fcs bit");
    endtask

    task automatic aborted_frame();
        int cursor;
        begin_test();
        make_payload(0, 24);
        // the error in payload word 3 is seen two words ahead of the output stage
        append_frame(0, 24, 1'b0, 13);
        append_idle(2);
        send_words();
        wait_frames(1);
        cursor = 0;
        check_frame(0, 8, 1'b1, 1'b0, cursor);
        pulse_totals(1, cursor);
        exp_bad++;
        finish_test("4 error character in payload");
    endtask

    task automatic idle_and_back_to_back();
        int cursor;
        begin_test();
        append_idle(3);
        push_byte(xgmii_term, 1'b1);
        for (int i = 0; i < 3; i++) begin
            push_byte(xgmii_idle, 1'b1);
        end
        // terminate in lane 2 after two data lanes
        push_byte(8'h11, 1'b0);
        push_byte(8'h22, 1'b0);
        push_byte(xgmii_term, 1'b1);
        push_byte(xgmii_idle, 1'b1);
        append_idle(4);
        send_words();
        repeat (4) @(negedge clk);
        pulse_totals(0, 0);
        make_payload(0, 16);
        make_payload(64, 14);
        append_frame(0, 16, 1'b0, -1);
        append_idle(1);
        append_frame(64, 14, 1'b0, -1);
        append_idle(2);
        send_words();
        wait_frames(2);
        cursor = 0;
        check_frame(0, 16, 1'b0, 1'b0, cursor);
        check_frame(64, 14, 1'b0, 1'b0, cursor);
        pulse_totals(2, cursor);
        exp_good = exp_good + 2;
        finish_test("5 stray characters and back-to-back frames");
    endtask

    task automatic counter_totals();
        begin_test();
        expect_count("count_good", exp_good, count_good);
        expect_count("count_bad", exp_bad, count_bad);
        expect_count("count_fcs", exp_fcs, count_fcs);
        finish_test("6 frame counters");
    endtask

    initial begin
        seed = 60;
        reset_crc = 1'b1;
        xgmii_rxd = {4{xgmii_idle}};
        xgmii_rxc = 4'hF;
        repeat (5) @(negedge clk);
        reset_crc = 1'b0;
        good_frame();
        short_tails();
        corrupted_fcs();
        aborted_frame();
        idle_and_back_to_back();
        counter_totals();
        $display("summary: %0d tests ok, %0d tests failed", tests_ok, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/xgmii_rx_pkg.sv
hw/xgmii_rx_delay.sv
hw/eth_crc32_lanes.sv
hw/xgmii_rx_ctrl.sv
hw/xgmii_rx_stats.sv
hw/xgmii_rx_top.sv
verification/xgmii_rx_clkgen.sv
verification/xgmii_rx_tb.sv

/* Bender.yml */
package:
  name: xgmii_rx

sources:
  - hw/xgmii_rx_pkg.sv
  - hw/xgmii_rx_delay.sv
  - hw/eth_crc32_lanes.sv
  - hw/xgmii_rx_ctrl.sv
  - hw/xgmii_rx_stats.sv
  - hw/xgmii_rx_top.sv
  - target: test
    files:
      - verification/xgmii_rx_clkgen.sv
      - verification/xgmii_rx_tb.sv
